/* kmulPkg.sv */
// ====================
// Shared widths and types for the Karatsuba multiplier
// ====================
package kmulPkg;

    // Significand width as seen by the requesters
    localparam int opWidth = 24;

    // Requester channels sharing the multiplier
    localparam int numChan = 2;

    // Tag travels with the request and comes back untouched
    localparam int tagWidth = 4;

    // Index of a requester channel
    typedef logic [$clog2(numChan)-1:0] chanIdT;

    // ====================
    // Request side
    // ====================
    // One operand pair plus the sender's tag
    typedef struct packed {
        logic [tagWidth-1:0] tag;
        logic [opWidth-1:0]  opA;
        logic [opWidth-1:0]  opB;
    } mulReqT;

    // ====================
    // Response side
    // ====================
    // Full-width product with the identity of its request
    typedef struct packed {
        chanIdT                chan;
        logic [tagWidth-1:0]   tag;
        logic [2*opWidth-1:0]  product;
    } mulRespT;

endpackage

/* partialMult.sv */
`timescale 1ns/1ps

// Registered unsigned multiplier
// One of the three sub-products of the Karatsuba stage
module partialMult #(
    parameter int w = 12
) (
    input  logic           clk,
    input  logic [w-1:0]   a_i,
    input  logic [w-1:0]   b_i,
    output logic [2*w-1:0] p_o
);

    // Free-running product register
    // Operands are extended to the result width before the multiply
    always_ff @(posedge clk) begin
        p_o <= a_i * b_i;
    end

endmodule

/* karatsubaStage.sv */
`timescale 1ns/1ps

// One-level Karatsuba significand multiplier
// Three registered sub-products, a combine step and a loaded result register
module karatsubaStage #(
    parameter int sw = kmulPkg::opWidth
) (
    input  logic            clk,
    input  logic            rstN_i,
    input  logic            load_i,
    input  logic [sw-1:0]   opA_i,
    input  logic [sw-1:0]   opB_i,
    output logic [2*sw-1:0] product_o
);

    // ====================
    // Operand split
    // ====================
    // Upper half takes sw/2 bits, lower half takes the rest
    localparam int hw = sw / 2;
    localparam int lw = sw - hw;
    // Half sums carry one extra bit
    localparam int mw = lw + 1;
    localparam int cw = 2 * mw;
    localparam int pw = 2 * sw;

    logic [hw-1:0]   aHigh;
    logic [hw-1:0]   bHigh;
    logic [lw-1:0]   aLow;
    logic [lw-1:0]   bLow;
    logic [mw-1:0]   aSum;
    logic [mw-1:0]   bSum;
    logic [2*hw-1:0] qLeft;
    logic [2*lw-1:0] qRight;
    logic [cw-1:0]   qMiddle;
    logic [cw-1:0]   qCross;
    logic [pw-1:0]   combined;

    assign aHigh = opA_i[sw-1 -: hw];
    assign bHigh = opB_i[sw-1 -: hw];
    assign aLow  = opA_i[lw-1:0];
    assign bLow  = opB_i[lw-1:0];

    // Half sums feed the middle product
    assign aSum = mw'(aHigh) + mw'(aLow);
    assign bSum = mw'(bHigh) + mw'(bLow);

    // ====================
    // Sub-products
    // ====================
    // High halves
    partialMult #(.w(hw)) leftMult (
        .clk (clk),
        .a_i (aHigh),
        .b_i (bHigh),
        .p_o (qLeft)
    );

    // Low halves
    partialMult #(.w(lw)) rightMult (
        .clk (clk),
        .a_i (aLow),
        .b_i (bLow),
        .p_o (qRight)
    );

    // Half sums
    partialMult #(.w(mw)) middleMult (
        .clk (clk),
        .a_i (aSum),
        .b_i (bSum),
        .p_o (qMiddle)
    );

    // ====================
    // Combine and load
    // ====================
    // Cross term aH*bL + aL*bH is never negative
    assign qCross = qMiddle - cw'(qLeft) - cw'(qRight);

    // Outer products sit side by side, cross term lands at the low-half boundary
    assign combined = {qLeft, qRight} + (pw'(qCross) << lw);

    // Holds its value until the next completing item
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            product_o <= '0;
        end else if (load_i) begin
            product_o <= combined;
        end
    end

endmodule

/* reqQueue.sv */
`timescale 1ns/1ps

// Per-channel request FIFO
// Each pop hands one credit back to the sender a cycle later
module reqQueue #(
    parameter int depth = 4
) (
    input  logic            clk,
    input  logic            rstN_i,
    input  logic            push_i,
    input  kmulPkg::mulReqT pushData_i,
    input  logic            pop_i,
    output kmulPkg::mulReqT head_o,
    output logic            notEmpty_o,
    output logic            creditReturn_o
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    // Entry storage
    kmulPkg::mulReqT mem [depth];

    logic [ptrW-1:0] rdPtr;
    logic [ptrW-1:0] wrPtr;
    logic [cntW-1:0] count;
    logic            doPush;
    logic            doPop;
    logic            full;

    assign full       = (count == cntW'(depth));
    assign notEmpty_o = (count != '0);
    // Credits keep the sender from ever pushing into a full queue
    assign doPush     = push_i && !full;
    assign doPop      = pop_i && notEmpty_o;

    // Head is valid whenever the queue holds an entry
    assign head_o = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData_i;
        end
    end

    // ====================
    // Pointers and count
    // ====================
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            rdPtr          <= '0;
            wrPtr          <= '0;
            count          <= '0;
            creditReturn_o <= 1'b0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
            // Registered pop pulse is the credit
            creditReturn_o <= doPop;
        end
    end

endmodule

/* rrArbiter.sv */
`timescale 1ns/1ps

// Round-robin arbiter over the non-empty request queues
// Grant is combinational, only the last winner is stored
module rrArbiter (
    input  logic                         clk,
    input  logic                         rstN_i,
    input  logic [kmulPkg::numChan-1:0]  req_i,
    output logic [kmulPkg::numChan-1:0]  grant_o,
    output logic                         issue_o,
    output kmulPkg::chanIdT              grantChan_o
);

    // Last granted channel
    kmulPkg::chanIdT lastPtr;

    // Search starts one past the last winner
    always_comb begin
        int   idx;
        logic found;
        grant_o     = '0;
        grantChan_o = '0;
        found       = 1'b0;
        for (int i = 1; i <= kmulPkg::numChan; i++) begin
            idx = (int'(lastPtr) + i) % kmulPkg::numChan;
            if (!found && req_i[idx]) begin
                grant_o[idx] = 1'b1;
                grantChan_o  = kmulPkg::chanIdT'(idx);
                found        = 1'b1;
            end
        end
    end

    // Any grant issues one item to the stage
    assign issue_o = |grant_o;

    // Out of reset the last channel counts as last winner, so channel 0 leads
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            lastPtr <= kmulPkg::chanIdT'(kmulPkg::numChan - 1);
        end else if (issue_o) begin
            lastPtr <= grantChan_o;
        end
    end

endmodule

/* resultRouter.sv */
`timescale 1ns/1ps

// Carries channel and tag of each issued item alongside the multiplier
// Two stages deep, matching the stage latency
module resultRouter (
    input  logic                         clk,
    input  logic                         rstN_i,
    input  logic                         issue_i,
    input  kmulPkg::chanIdT              issueChan_i,
    input  logic [kmulPkg::tagWidth-1:0] issueTag_i,
    output logic                         loadStage_o,
    output logic                         respValid_o,
    output kmulPkg::chanIdT              respChan_o,
    output logic [kmulPkg::tagWidth-1:0] respTag_o
);

    kmulPkg::chanIdT              chanQ1;
    logic [kmulPkg::tagWidth-1:0] tagQ1;

    // Valid pipeline
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            loadStage_o <= 1'b0;
            respValid_o <= 1'b0;
        end else begin
            // First stage lines up with the registered sub-products
            loadStage_o <= issue_i;
            // Second stage lines up with the product register
            respValid_o <= loadStage_o;
        end
    end

    // Channel and tag ride along with the valid bits
    always_ff @(posedge clk) begin
        chanQ1     <= issueChan_i;
        tagQ1      <= issueTag_i;
        respChan_o <= chanQ1;
        respTag_o  <= tagQ1;
    end

endmodule

/* kmulTop.sv */
`timescale 1ns/1ps

// Shared Karatsuba significand multiplier with two credit-controlled channels
module kmulTop #(
    parameter int queueDepth = 4,
    parameter int opWidthP   = kmulPkg::opWidth
) (
    input  logic                        clk,
    input  logic                        rstN_i,
    input  logic [kmulPkg::numChan-1:0] reqValid_i,
    input  kmulPkg::mulReqT             reqData_i [kmulPkg::numChan],
    output logic [kmulPkg::numChan-1:0] creditReturn_o,
    output logic                        respValid_o,
    output kmulPkg::mulRespT            respData_o
);

    kmulPkg::mulReqT              headData [kmulPkg::numChan];
    logic [kmulPkg::numChan-1:0]  notEmpty;
    logic [kmulPkg::numChan-1:0]  grant;
    logic                         issue;
    kmulPkg::chanIdT              grantChan;
    kmulPkg::mulReqT              issueReq;
    logic                         loadStage;
    kmulPkg::chanIdT              respChan;
    logic [kmulPkg::tagWidth-1:0] respTag;
    logic [2*opWidthP-1:0]        product;

    // ====================
    // Request queues
    // ====================
    for (genvar c = 0; c < kmulPkg::numChan; c++) begin : chanGen
        reqQueue #(.depth(queueDepth)) reqQueue_inst (
            .clk            (clk),
            .rstN_i         (rstN_i),
            .push_i         (reqValid_i[c]),
            .pushData_i     (reqData_i[c]),
            .pop_i          (grant[c]),
            .head_o         (headData[c]),
            .notEmpty_o     (notEmpty[c]),
            .creditReturn_o (creditReturn_o[c])
        );
    end

    rrArbiter rrArbiter_inst (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .req_i       (notEmpty),
        .grant_o     (grant),
        .issue_o     (issue),
        .grantChan_o (grantChan)
    );

    // Granted head goes to the multiplier
    assign issueReq = headData[grantChan];

    // ====================
    // Shared multiplier
    // ====================
    karatsubaStage #(.sw(opWidthP)) karatsubaStage_inst (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .load_i    (loadStage),
        .opA_i     (issueReq.opA),
        .opB_i     (issueReq.opB),
        .product_o (product)
    );

    // Router owns the load timing of the product register
    resultRouter resultRouter_inst (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .issue_i     (issue),
        .issueChan_i (grantChan),
        .issueTag_i  (issueReq.tag),
        .loadStage_o (loadStage),
        .respValid_o (respValid_o),
        .respChan_o  (respChan),
        .respTag_o   (respTag)
    );

    assign respData_o = '{chan: respChan, tag: respTag, product: product};

endmodule

/* tbChecker.sv */
`timescale 1ns/1ps

// Scoreboard for the shared multiplier
// Tracks credits, grant order and every response against the test data
module tbChecker #(
    parameter int maxLines   = 64
) (
    input  logic                        clk,
    input  logic                        rstN_i,
    input  logic [kmulPkg::numChan-1:0] reqValid_i,
    input  logic [kmulPkg::numChan-1:0] creditReturn_i,
    input  logic                        respValid_i,
    input  kmulPkg::mulRespT            respData_i,
    input  logic                        finish_i,
    output int                          respCount_o,
    output int                          errorCount_o,
    output logic                        reportDone_o
);

    localparam int nc = kmulPkg::numChan;

    // One expected response
    typedef struct packed {
        logic [7:0]                    testNum;
        logic [kmulPkg::tagWidth-1:0]  tag;
        logic [2*kmulPkg::opWidth-1:0] product;
    } expEntryT;

    logic [47:0]   testData [6*maxLines];
    expEntryT      expQ [nc][$];
    int            remaining [16];
    int            testErrors [16];
    int            testsDone;
    int            sentCount [nc];
    int            creditCount [nc];
    // Queue occupancy as seen one edge late
    int            occ [nc];
    logic [nc-1:0] pushPrev;
    logic          allWaiting;
    int            lastPop;

    // ====================
    // Expected responses
    // ====================
    initial begin
        expEntryT entry;
        respCount_o  = 0;
        errorCount_o = 0;
        reportDone_o = 1'b0;
        testsDone    = 0;
        for (int i = 0; i < 6 * maxLines; i++) begin
            testData[i] = {16'hF11E, 32'(i)};
        end
        $readmemh("kmul_testdata.hex", testData);
        // Real lines carry a small test number
        for (int i = 0; i < maxLines; i++) begin
            if (testData[6 * i] < 48'd16) begin
                entry.testNum = testData[6 * i][7:0];
                entry.tag     = testData[6 * i + 2][kmulPkg::tagWidth-1:0];
                entry.product = testData[6 * i + 5][2*kmulPkg::opWidth-1:0];
                expQ[int'(testData[6 * i + 1])].push_back(entry);
                remaining[int'(entry.testNum)]++;
            end
        end
    end

    task automatic checkResponse(input kmulPkg::mulRespT resp);
        expEntryT exp;
        int       ch;
        int       tn;
        ch = int'(resp.chan);
        respCount_o++;
        if (expQ[ch].size() == 0) begin
            $display("Response on channel %0d at %0t with no request outstanding", ch, $time);
            errorCount_o++;
            return;
        end
        exp = expQ[ch].pop_front();
        tn  = int'(exp.testNum);
        if (resp.tag !== exp.tag) begin
            $display("FAILED %0t respData_o.tag expected %h got %h", $time, exp.tag, resp.tag);
            errorCount_o++;
            testErrors[tn]++;
        end
        if (resp.product !== exp.product) begin
            $display("FAILED %0t respData_o.product expected %h got %h",
                     $time, exp.product, resp.product);
            errorCount_o++;
            testErrors[tn]++;
        end
        remaining[tn]--;
        if (remaining[tn] == 0) begin
            testsDone++;
            $display("test %0d finished with %0d mismatches", tn, testErrors[tn]);
        end
    endtask

    // Credit totals must match once everything has drained
    task automatic closeRun();
        for (int c = 0; c < nc; c++) begin
            if (creditCount[c] != sentCount[c]) begin
                $display("Channel %0d returned %0d credits for %0d requests",
                         c, creditCount[c], sentCount[c]);
                errorCount_o++;
            end
            if (expQ[c].size() != 0) begin
                $display("Channel %0d is still missing %0d responses", c, expQ[c].size());
                errorCount_o++;
            end
        end
        $display("Tests finished %0d, responses %0d, errors %0d",
                 testsDone, respCount_o, errorCount_o);
        reportDone_o = 1'b1;
    endtask

    // ====================
    // Per-cycle monitor
    // ====================
    always @(posedge clk) begin
        logic [nc-1:0] expPop;
        if (!rstN_i) begin
            for (int c = 0; c < nc; c++) begin
                occ[c] = 0;
            end
            pushPrev   = '0;
            allWaiting = 1'b0;
            // Arbiter leaves reset with the last channel as winner
            lastPop    = nc - 1;
        end else begin
            // creditReturn marks the pop made one edge earlier
            if (allWaiting) begin
                expPop = '0;
                expPop[(lastPop + 1) % nc] = 1'b1;
                if (creditReturn_i !== expPop) begin
                    $display("FAILED %0t creditReturn_o expected %b got %b",
                             $time, expPop, creditReturn_i);
                    errorCount_o++;
                end
            end
            allWaiting = 1'b1;
            for (int c = 0; c < nc; c++) begin
                if (creditReturn_i[c]) begin
                    lastPop = c;
                end
                sentCount[c]   += int'(reqValid_i[c]);
                creditCount[c] += int'(creditReturn_i[c]);
                occ[c] = occ[c] + int'(pushPrev[c]) - int'(creditReturn_i[c]);
                // A credit can only follow a queued request
                if (occ[c] < 0) begin
                    $display("Channel %0d returned a credit with no request queued at %0t",
                             c, $time);
                    errorCount_o++;
                    occ[c] = 0;
                end
                if (occ[c] == 0) begin
                    allWaiting = 1'b0;
                end
            end
            pushPrev = reqValid_i;
            if (respValid_i) begin
                checkResponse(respData_i);
            end
            if (finish_i && !reportDone_o) begin
                closeRun();
            end
        end
    end

endmodule

/* tbTop.sv */
`timescale 1ns/1ps

// Testbench top for the shared Karatsuba multiplier
// Drives both request channels under credit control from the test data file
module tbTop;

    localparam int queueDepth = 4;
    localparam int maxLines   = 64;
    localparam int numTests   = 5;
    localparam int nc         = kmulPkg::numChan;

    logic             clk = 1'b0;
    logic             rstN;
    logic [nc-1:0]    reqValid;
    kmulPkg::mulReqT  reqData [nc];
    logic [nc-1:0]    creditReturn;
    logic             respValid;
    kmulPkg::mulRespT respData;
    logic             finishRun;
    logic             reportDone;
    int               respCount;
    int               errorCount;

    logic [47:0] testData [6*maxLines];
    int          numLines;
    int          sentTotal;
    int          sentCount [nc];
    int          returnCount [nc];

    // 10 ns clock
    always #5 clk = ~clk;

    kmulTop #(.queueDepth(queueDepth), .opWidthP(kmulPkg::opWidth)) kmulTop_inst (
        .clk            (clk),
        .rstN_i         (rstN),
        .reqValid_i     (reqValid),
        .reqData_i      (reqData),
        .creditReturn_o (creditReturn),
        .respValid_o    (respValid),
        .respData_o     (respData)
    );

    tbChecker #(.maxLines(maxLines)) tbChecker_inst (
        .clk            (clk),
        .rstN_i         (rstN),
        .reqValid_i     (reqValid),
        .creditReturn_i (creditReturn),
        .respValid_i    (respValid),
        .respData_i     (respData),
        .finish_i       (finishRun),
        .respCount_o    (respCount),
        .errorCount_o   (errorCount),
        .reportDone_o   (reportDone)
    );

    // One credit back per pulse
    always @(posedge clk) begin
        for (int c = 0; c < nc; c++) begin
            if (rstN && creditReturn[c]) begin
                returnCount[c] <= returnCount[c] + 1;
            end
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    // ====================
    // Request driver
    // ====================
    task automatic sendChannel(input int ch, input int testNum);
        int base;
        int gap;
        for (int i = 0; i < numLines; i++) begin
            base = 6 * i;
            if (int'(testData[base]) == testNum && int'(testData[base + 1]) == ch) begin
                // Hold the request until a credit is free
                while (queueDepth - sentCount[ch] + returnCount[ch] <= 0) begin
                    stepCycle();
                end
                reqData[ch] = '{tag: testData[base + 2][kmulPkg::tagWidth-1:0],
                                opA: testData[base + 3][kmulPkg::opWidth-1:0],
                                opB: testData[base + 4][kmulPkg::opWidth-1:0]};
                reqValid[ch] = 1'b1;
                sentCount[ch]++;
                sentTotal++;
                stepCycle();
                reqValid[ch] = 1'b0;
                // Last two tests send back to back
                if (testNum < 4) begin
                    gap = int'($urandom_range(3, 0));
                    repeat (gap) stepCycle();
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h0d86_b726));
        rstN      = 1'b0;
        reqValid  = '0;
        finishRun = 1'b0;
        sentTotal = 0;
        numLines  = 0;
        for (int c = 0; c < nc; c++) begin
            reqData[c] = '0;
        end
        for (int i = 0; i < 6 * maxLines; i++) begin
            testData[i] = {16'hF11E, 32'(i)};
        end
        $readmemh("kmul_testdata.hex", testData);
        // Real lines carry a small test number, the fill never does
        while (numLines < maxLines && testData[6 * numLines] < 48'd16) begin
            numLines++;
        end
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
        for (int t = 1; t <= numTests; t++) begin
            fork
                sendChannel(0, t);
                sendChannel(1, t);
            join
            // Drain so the next test starts from empty queues
            wait (respCount == sentTotal);
            stepCycle();
        end
        finishRun = 1'b1;
        wait (reportDone);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // ====================
    // Watchdog
    // ====================
    initial begin
        int limitCycles;
        #1;
        limitCycles = 40 * numLines + 100;
        #(limitCycles * 10);
        $display("Watchdog timeout, run still busy after %0d cycles", limitCycles);
        $display("Test failed");
        $finish;
    end

endmodule

/* kmul_testdata.hex */
// test chan tag opA opB expectedProduct, all fields hex, one request per line
// test 1 ch0 alone, 2 ch1 alone, 3 corners, 4 both channels, 5 credit burst
1 0 1 123456 000100 000012345600
1 0 2 00FFFF 010001 0000FFFFFFFF
1 0 3 249249 000007 000000FFFFFF
1 0 4 FFFFFF 000FFF 000FFEFFF001
2 1 5 0F0F0F 000011 000000FFFFFF
2 1 6 400000 000400 000100000000
2 1 7 001001 001001 000001002001
2 1 8 ABCDEF 000010 00000ABCDEF0
3 0 9 000000 ABCDEF 000000000000
3 1 9 000001 FEDCBA 000000FEDCBA
3 0 A FFFFFF FFFFFF FFFFFE000001
3 1 A FFF000 000FFF 000FFE001000
3 0 B 800001 800001 400001000001
3 1 B AAAAAA 000003 000001FFFFFE
3 0 C 555555 000006 000001FFFFFE
3 1 C FFF000 FFF000 FFE001000000
4 0 0 000002 000003 000000000006
4 0 1 000010 000010 000000000100
4 0 2 111111 00000F 000000FFFFFF
4 0 3 010101 0000FF 000000FFFFFF
4 0 4 001000 001000 000001000000
4 1 0 7FFFFF 000002 000000FFFFFE
4 1 1 FFFFFF 000002 000001FFFFFE
4 1 2 123456 000002 0000002468AC
4 1 3 FFFFFF 001000 000FFFFFF000
4 1 4 000FFF 000FFF 000000FFE001
5 0 5 000100 000100 000000010000
5 0 6 100000 000010 000001000000
5 0 7 000800 000800 000000400000
5 0 8 FFFFFF 000001 000000FFFFFF
5 1 5 020000 000080 000001000000
5 1 6 003000 000003 000000009000
5 1 7 0000FF 0000FF 00000000FE01
5 1 8 FFFFFF 000000 000000000000

/* tb.f */
kmulPkg.sv
partialMult.sv
karatsubaStage.sv
reqQueue.sv
rrArbiter.sv
resultRouter.sv
kmulTop.sv
tbChecker.sv
tbTop.sv

/* Makefile */
# Verilator simulation of the shared Karatsuba multiplier

VERILATOR  := verilator
TOP        := tbTop
FILELIST   := tb.f
BUILDFLAGS := --binary --timing --top-module $(TOP)
LINTFLAGS  := --lint-only -Wall --timing --top-module $(TOP)
PASSMSG    := Test completed successfully
SIM        := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILDFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASSMSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf obj_dir
